/* source/dcache_pkg.sv */
// shared widths, request and response structs and access kinds for the dcache memory block
package dcache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned WORD_WIDTH     = 32;
  localparam int unsigned WORD_BYTES     = WORD_WIDTH / 8;
  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned LINE_WIDTH     = NUM_BANKS * WORD_WIDTH;
  localparam int unsigned IDX_WIDTH      = 6;
  localparam int unsigned NUM_SETS       = 2 ** IDX_WIDTH;
  localparam int unsigned TAG_WIDTH      = 8;
  localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);

  typedef logic [NUM_WAYS-1:0]  way_vec_t;
  typedef logic [NUM_BANKS-1:0] bank_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // port payloads
  ////////////////////////////////////////////////////////////////////////////

  // one read port, tag travels with the request
  typedef struct packed {
    logic [TAG_WIDTH-1:0]      tag;
    logic [IDX_WIDTH-1:0]      idx;
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic                      tag_only;
    logic                      prio;
  } rd_req_t;

  // full line refill, writes tag and valid bits as well
  typedef struct packed {
    logic                  vld;
    way_vec_t              ways;
    logic [TAG_WIDTH-1:0]  tag;
    logic [IDX_WIDTH-1:0]  idx;
    way_vec_t              vld_bits;
    logic [LINE_WIDTH-1:0] data;
  } fill_req_t;

  typedef struct packed {
    way_vec_t                  ways;
    logic [IDX_WIDTH-1:0]      idx;
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic [WORD_WIDTH-1:0]     data;
    logic [WORD_BYTES-1:0]     be;
  } word_wr_t;

  typedef struct packed {
    way_vec_t              vld_bits;
    way_vec_t              hit_oh;
    logic [WORD_WIDTH-1:0] data;
  } rd_rsp_t;

  // what the arrays did in the previous cycle
  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_READ,
    ACC_TAG_ONLY,
    ACC_FILL
  } access_e;

endpackage

/* source/dcache_sram.sv */
// single-port memory with byte enables, registered read data and reset to zero
`timescale 1ns/10ps

module dcache_sram #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned Depth     = 64
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [$clog2(Depth)-1:0]       addr_i,
  input  logic [DataWidth-1:0]           wdata_i,
  input  logic [(DataWidth+7)/8-1:0]     be_i,
  output logic [DataWidth-1:0]           rdata_o
);

  logic [DataWidth-1:0] mem_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mem
    if (!rst_ni) begin
      for (int a = 0; a < Depth; a++) begin
        mem_q[a] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        // a partial top byte is covered by the last enable bit
        for (int i = 0; i < DataWidth; i++) begin
          if (be_i[i/8]) begin
            mem_q[addr_i][i] <= wdata_i[i];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* source/dcache_port_arbiter.sv */
// priority masking and round-robin grant among the dcache read ports
`timescale 1ns/10ps

module dcache_port_arbiter #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [NumPorts-1:0]         req_valid_i,
  input  logic [NumPorts-1:0]         req_prio_i,
  input  logic                        block_i,
  output logic [NumPorts-1:0]         gnt_o,
  output logic [$clog2(NumPorts)-1:0] gnt_idx_o,
  output logic                        gnt_valid_o
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  logic [NumPorts-1:0] req_hi;
  logic [NumPorts-1:0] req_masked;
  logic [IdxWidth-1:0] ptr_d, ptr_q;
  logic                found;

  // any high priority request hides all low priority ones
  assign req_hi     = req_valid_i & req_prio_i;
  assign req_masked = (|req_hi) ? req_hi : req_valid_i;

  // first remaining request at or after the pointer
  always_comb begin : p_rr_search
    int unsigned cand;
    found     = 1'b0;
    gnt_idx_o = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = ptr_q + i;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!found && req_masked[cand]) begin
        found     = 1'b1;
        gnt_idx_o = cand[IdxWidth-1:0];
      end
    end
  end

  assign gnt_valid_o = found & ~block_i;

  always_comb begin : p_gnt_oh
    for (int p = 0; p < NumPorts; p++) begin
      gnt_o[p] = gnt_valid_o && (gnt_idx_o == IdxWidth'(p));
    end
  end

  // move one past the winner
  assign ptr_d = (gnt_idx_o == IdxWidth'(NumPorts - 1)) ? '0 : gnt_idx_o + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_valid_o) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

/* source/dcache_bank_ctrl.sv */
// steering of refill, granted read and word write onto data bank and tag array controls
`timescale 1ns/10ps

module dcache_bank_ctrl #(
  parameter int unsigned NumPorts = 3
) (
  input  dcache_pkg::rd_req_t [NumPorts-1:0]        rd_req_i,
  input  logic [$clog2(NumPorts)-1:0]               gnt_idx_i,
  input  logic                                      gnt_valid_i,
  input  dcache_pkg::fill_req_t                     fill_i,
  input  dcache_pkg::word_wr_t                      wr_i,
  input  logic                                      wr_valid_i,
  output logic                                      arb_block_o,
  output logic                                      wr_ack_o,
  output dcache_pkg::bank_vec_t                     bank_req_o,
  output dcache_pkg::bank_vec_t                     bank_we_o,
  output logic [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::IDX_WIDTH-1:0] bank_idx_o,
  output logic [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::LINE_WIDTH-1:0] bank_wdata_o,
  output logic [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS*dcache_pkg::WORD_BYTES-1:0]
                                                    bank_be_o,
  output dcache_pkg::way_vec_t                      tag_req_o,
  output logic                                      tag_we_o,
  output logic [dcache_pkg::IDX_WIDTH-1:0]          tag_idx_o,
  output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_WIDTH:0] tag_wdata_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]          cmp_tag_o,
  output logic [dcache_pkg::BANK_SEL_WIDTH-1:0]     cmp_bank_o,
  output dcache_pkg::access_e                       access_o
);

  localparam int unsigned WordWidth = dcache_pkg::WORD_WIDTH;
  localparam int unsigned WordBytes = dcache_pkg::WORD_BYTES;

  dcache_pkg::rd_req_t rd;
  logic                collision;

  assign rd          = rd_req_i[gnt_idx_i];
  assign arb_block_o = fill_i.vld;
  assign cmp_tag_o   = rd.tag;
  assign cmp_bank_o  = rd.bank_sel;

  // only a data read on the same bank stalls the word write
  assign collision = gnt_valid_i & ~rd.tag_only & (rd.bank_sel == wr_i.bank_sel);
  assign wr_ack_o  = ~fill_i.vld & ~collision;

  always_comb begin : p_steer
    bank_req_o   = '0;
    bank_we_o    = '0;
    bank_idx_o   = {dcache_pkg::NUM_BANKS{wr_i.idx}};
    bank_wdata_o = {dcache_pkg::NUM_BANKS * dcache_pkg::NUM_WAYS{wr_i.data}};
    bank_be_o    = '0;
    tag_req_o    = '0;
    tag_we_o     = 1'b0;
    tag_idx_o    = rd.idx;
    access_o     = dcache_pkg::ACC_IDLE;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      tag_wdata_o[w] = {fill_i.vld_bits[w], fill_i.tag};
    end

    if (fill_i.vld) begin
      // whole line, ways without a set bit keep their contents
      access_o   = dcache_pkg::ACC_FILL;
      tag_req_o  = fill_i.ways;
      tag_we_o   = 1'b1;
      tag_idx_o  = fill_i.idx;
      bank_req_o = '1;
      bank_we_o  = '1;
      for (int k = 0; k < dcache_pkg::NUM_BANKS; k++) begin
        bank_idx_o[k]   = fill_i.idx;
        bank_wdata_o[k] = {dcache_pkg::NUM_WAYS{fill_i.data[k*WordWidth +: WordWidth]}};
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
          bank_be_o[k][w*WordBytes +: WordBytes] = {WordBytes{fill_i.ways[w]}};
        end
      end
    end else begin
      if (gnt_valid_i) begin
        tag_req_o = '1;
        access_o  = rd.tag_only ? dcache_pkg::ACC_TAG_ONLY : dcache_pkg::ACC_READ;
        if (!rd.tag_only) begin
          bank_req_o[rd.bank_sel] = 1'b1;
          bank_idx_o[rd.bank_sel] = rd.idx;
        end
      end
      if (wr_valid_i && wr_ack_o) begin
        bank_req_o[wr_i.bank_sel] = 1'b1;
        bank_we_o[wr_i.bank_sel]  = 1'b1;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
          bank_be_o[wr_i.bank_sel][w*WordBytes +: WordBytes] = wr_i.ways[w] ? wr_i.be : '0;
        end
      end
    end
  end

endmodule

/* source/dcache_hit_select.sv */
// read context registers, tag compare, hit vector and word selection
`timescale 1ns/10ps

module dcache_hit_select (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]        cmp_tag_i,
  input  logic [dcache_pkg::BANK_SEL_WIDTH-1:0]   cmp_bank_i,
  input  dcache_pkg::access_e                     access_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_WIDTH:0] tag_rdata_i,
  input  logic [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::LINE_WIDTH-1:0] bank_rdata_i,
  output dcache_pkg::rd_rsp_t                     rd_rsp_o
);

  localparam int unsigned WordWidth = dcache_pkg::WORD_WIDTH;

  logic [dcache_pkg::TAG_WIDTH-1:0]      tag_q;
  logic [dcache_pkg::BANK_SEL_WIDTH-1:0] bank_q;
  dcache_pkg::access_e                   access_q;
  logic                                  cmp_en;
  dcache_pkg::way_vec_t                  vld_bits;
  dcache_pkg::way_vec_t                  hit_oh;
  logic [WordWidth-1:0]                  rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctx
    if (!rst_ni) begin
      tag_q    <= '0;
      bank_q   <= '0;
      access_q <= dcache_pkg::ACC_IDLE;
    end else begin
      tag_q    <= cmp_tag_i;
      bank_q   <= cmp_bank_i;
      access_q <= access_i;
    end
  end

  assign cmp_en = (access_q == dcache_pkg::ACC_READ) || (access_q == dcache_pkg::ACC_TAG_ONLY);

  // top bit of each tag word is the valid bit
  for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : gen_cmp
    assign vld_bits[w] = tag_rdata_i[w][dcache_pkg::TAG_WIDTH];
    assign hit_oh[w]   = cmp_en & vld_bits[w] &
                         (tag_rdata_i[w][dcache_pkg::TAG_WIDTH-1:0] == tag_q);
  end

  // lowest hitting way wins, zero on miss or tag-only
  always_comb begin : p_word_sel
    rdata = '0;
    for (int w = dcache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_oh[w] && access_q == dcache_pkg::ACC_READ) begin
        rdata = bank_rdata_i[bank_q][w*WordWidth +: WordWidth];
      end
    end
  end

  assign rd_rsp_o = '{vld_bits: vld_bits, hit_oh: hit_oh, data: rdata};

endmodule

/* source/dcache_mem.sv */
// dcache memory block top level with arbiter, bank control, data banks, tag arrays and hit select
`timescale 1ns/10ps

module dcache_mem #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  dcache_pkg::rd_req_t [NumPorts-1:0] rd_req_i,
  input  logic [NumPorts-1:0]                rd_valid_i,
  output logic [NumPorts-1:0]                rd_ack_o,
  input  dcache_pkg::fill_req_t              fill_i,
  input  dcache_pkg::word_wr_t               wr_i,
  input  logic                               wr_valid_i,
  output logic                               wr_ack_o,
  output dcache_pkg::rd_rsp_t                rd_rsp_o
);

  localparam int unsigned NumBanks = dcache_pkg::NUM_BANKS;
  localparam int unsigned NumWays  = dcache_pkg::NUM_WAYS;
  localparam int unsigned TagBits  = dcache_pkg::TAG_WIDTH + 1;

  logic [NumPorts-1:0]                   rd_prio;
  logic [$clog2(NumPorts)-1:0]           gnt_idx;
  logic                                  gnt_valid;
  logic                                  arb_block;
  dcache_pkg::bank_vec_t                 bank_req;
  dcache_pkg::bank_vec_t                 bank_we;
  logic [NumBanks-1:0][dcache_pkg::IDX_WIDTH-1:0]  bank_idx;
  logic [NumBanks-1:0][dcache_pkg::LINE_WIDTH-1:0] bank_wdata;
  logic [NumBanks-1:0][dcache_pkg::LINE_WIDTH-1:0] bank_rdata;
  logic [NumBanks-1:0][NumWays*dcache_pkg::WORD_BYTES-1:0] bank_be;
  dcache_pkg::way_vec_t                  tag_req;
  logic                                  tag_we;
  logic [dcache_pkg::IDX_WIDTH-1:0]      tag_idx;
  logic [NumWays-1:0][TagBits-1:0]       tag_wdata;
  logic [NumWays-1:0][TagBits-1:0]       tag_rdata;
  logic [dcache_pkg::TAG_WIDTH-1:0]      cmp_tag;
  logic [dcache_pkg::BANK_SEL_WIDTH-1:0] cmp_bank;
  dcache_pkg::access_e                   access;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_prio
    assign rd_prio[p] = rd_req_i[p].prio;
  end

  dcache_port_arbiter #(.NumPorts(NumPorts)) i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (rd_valid_i),
    .req_prio_i  (rd_prio),
    .block_i     (arb_block),
    .gnt_o       (rd_ack_o),
    .gnt_idx_o   (gnt_idx),
    .gnt_valid_o (gnt_valid)
  );

  dcache_bank_ctrl #(.NumPorts(NumPorts)) i_bank_ctrl (
    .rd_req_i (rd_req_i), .gnt_idx_i (gnt_idx), .gnt_valid_i (gnt_valid),
    .fill_i (fill_i), .wr_i (wr_i), .wr_valid_i (wr_valid_i),
    .arb_block_o (arb_block), .wr_ack_o (wr_ack_o),
    .bank_req_o (bank_req), .bank_we_o (bank_we), .bank_idx_o (bank_idx),
    .bank_wdata_o (bank_wdata), .bank_be_o (bank_be),
    .tag_req_o (tag_req), .tag_we_o (tag_we), .tag_idx_o (tag_idx),
    .tag_wdata_o (tag_wdata), .cmp_tag_o (cmp_tag), .cmp_bank_o (cmp_bank),
    .access_o (access)
  );

  ////////////////////////////////////////////////////////////////////////////
  // arrays, one data bank per word offset, one tag array per way
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NumBanks; k++) begin : gen_data_bank
    dcache_sram #(
      .DataWidth (dcache_pkg::LINE_WIDTH),
      .Depth     (dcache_pkg::NUM_SETS)
    ) i_data_sram (
      .clk_i (clk_i), .rst_ni (rst_ni), .req_i (bank_req[k]), .we_i (bank_we[k]),
      .addr_i (bank_idx[k]), .wdata_i (bank_wdata[k]), .be_i (bank_be[k]),
      .rdata_o (bank_rdata[k])
    );
  end

  for (genvar w = 0; w < NumWays; w++) begin : gen_tag_array
    dcache_sram #(
      .DataWidth (TagBits),
      .Depth     (dcache_pkg::NUM_SETS)
    ) i_tag_sram (
      .clk_i (clk_i), .rst_ni (rst_ni), .req_i (tag_req[w]), .we_i (tag_we),
      .addr_i (tag_idx), .wdata_i (tag_wdata[w]), .be_i ('1),
      .rdata_o (tag_rdata[w])
    );
  end

  dcache_hit_select i_hit_select (
    .clk_i (clk_i), .rst_ni (rst_ni), .cmp_tag_i (cmp_tag), .cmp_bank_i (cmp_bank),
    .access_i (access), .tag_rdata_i (tag_rdata), .bank_rdata_i (bank_rdata),
    .rd_rsp_o (rd_rsp_o)
  );

endmodule

/* bench/dcache_mem_tb.sv */
// testbench for the dcache memory block with reference model, stimulus, assertions and timeout
`timescale 1ns/10ps

module dcache_mem_tb;

  localparam int unsigned NumPorts  = 3;
  // the tests take under 2000 cycles
  localparam int unsigned MaxCycles = 4000;
  localparam int unsigned AckLimit  = 50;

  logic                               clk_i;
  logic                               rst_ni;
  dcache_pkg::rd_req_t [NumPorts-1:0] rd_req;
  logic [NumPorts-1:0]                rd_valid;
  logic [NumPorts-1:0]                rd_ack;
  logic [NumPorts-1:0]                prio_vec;
  dcache_pkg::fill_req_t              fill;
  dcache_pkg::word_wr_t               wr;
  logic                               wr_valid;
  logic                               wr_ack;
  dcache_pkg::rd_rsp_t                rd_rsp;

  // reference model of the arrays
  logic [dcache_pkg::TAG_WIDTH-1:0]  m_tag [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
  logic                              m_vld [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
  logic [dcache_pkg::WORD_WIDTH-1:0] m_data
      [dcache_pkg::NUM_BANKS][dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];

  logic [31:0]         rng_state;
  logic                ack_pend;
  logic                rsp_check;
  logic                exp_wr_ack;
  logic                rr_phase;
  dcache_pkg::rd_rsp_t exp_rsp_pend;
  dcache_pkg::rd_rsp_t exp_rsp_chk;
  int unsigned         ack_gap [NumPorts];
  int unsigned         cycles;

  dcache_mem #(.NumPorts(NumPorts)) dcache_mem_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .rd_req_i (rd_req), .rd_valid_i (rd_valid),
    .rd_ack_o (rd_ack), .fill_i (fill), .wr_i (wr), .wr_valid_i (wr_valid),
    .wr_ack_o (wr_ack), .rd_rsp_o (rd_rsp)
  );

  for (genvar p = 0; p < NumPorts; p++) begin : gen_prio
    assign prio_vec[p] = rd_req[p].prio;
  end

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic dcache_pkg::rd_req_t rand_req();
    logic [31:0] v;
    v = lcg_next();
    return '{tag: v[7:0], idx: v[13:8], bank_sel: v[15:14], tag_only: v[16], prio: 1'b0};
  endfunction

  function automatic dcache_pkg::fill_req_t rand_fill();
    dcache_pkg::fill_req_t f;
    logic [31:0]           v;
    v          = lcg_next();
    f.vld      = 1'b1;
    f.ways     = 4'b0001 << v[1:0];
    // low tag bits follow the way so two ways of a set never share a tag
    f.tag      = {v[9:4], v[1:0]};
    f.idx      = {3'b000, v[12:10]};
    f.vld_bits = {4{v[15:13] != 3'd0}};
    f.data     = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    return f;
  endfunction

  function automatic dcache_pkg::rd_rsp_t predict_rsp(input dcache_pkg::rd_req_t r);
    dcache_pkg::rd_rsp_t rsp;
    rsp = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      rsp.vld_bits[w] = m_vld[w][r.idx];
      if (m_vld[w][r.idx] && m_tag[w][r.idx] == r.tag) begin
        rsp.hit_oh[w] = 1'b1;
        if (!r.tag_only) begin
          rsp.data = m_data[r.bank_sel][r.idx][w];
        end
      end
    end
    return rsp;
  endfunction

  function automatic void apply_refill(input dcache_pkg::fill_req_t f);
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (f.ways[w]) begin
        m_tag[w][f.idx] = f.tag;
        m_vld[w][f.idx] = f.vld_bits[w];
        for (int k = 0; k < dcache_pkg::NUM_BANKS; k++) begin
          m_data[k][f.idx][w] = f.data[k*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];
        end
      end
    end
  endfunction

  function automatic void apply_word_write(input dcache_pkg::word_wr_t w);
    for (int y = 0; y < dcache_pkg::NUM_WAYS; y++) begin
      for (int b = 0; b < dcache_pkg::WORD_BYTES; b++) begin
        if (w.ways[y] && w.be[b]) begin
          m_data[w.bank_sel][w.idx][y][b*8 +: 8] = w.data[b*8 +: 8];
        end
      end
    end
  endfunction

  task automatic issue_read(input int p, input dcache_pkg::rd_req_t r);
    int waited;
    waited = 0;
    @(negedge clk_i);
    rd_req[p]   = r;
    rd_valid[p] = 1'b1;
    #10;
    while (!rd_ack[p]) begin
      if (waited >= AckLimit) begin
        report_failure($sformatf("read on port %0d was never acked", p));
      end else begin
        waited++;
        @(negedge clk_i);
        #10;
      end
    end
    @(negedge clk_i);
    rd_valid[p] = 1'b0;
  endtask

  task automatic issue_write(input dcache_pkg::word_wr_t w);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wr       = w;
    wr_valid = 1'b1;
    #10;
    while (!wr_ack) begin
      if (waited >= AckLimit) begin
        report_failure("word write was never acked");
      end else begin
        waited++;
        @(negedge clk_i);
        #10;
      end
    end
    @(negedge clk_i);
    wr_valid = 1'b0;
  endtask

  task automatic issue_fill(input dcache_pkg::fill_req_t f);
    @(negedge clk_i);
    fill = f;
    @(negedge clk_i);
    fill.vld = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor between the falling edge and the next rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    #10;
    // response of the previous cycle's ack is due at the coming rising edge
    rsp_check   = ack_pend;
    exp_rsp_chk = exp_rsp_pend;
    ack_pend    = 1'b0;
    exp_wr_ack  = !fill.vld;
    for (int p = 0; p < NumPorts; p++) begin
      if (rd_ack[p]) begin
        ack_pend     = 1'b1;
        exp_rsp_pend = predict_rsp(rd_req[p]);
        if (!rd_req[p].tag_only && rd_req[p].bank_sel == wr.bank_sel) begin
          exp_wr_ack = 1'b0;
        end
      end
      if (!rr_phase || rd_ack[p]) begin
        ack_gap[p] = 0;
      end else if (|rd_ack) begin
        ack_gap[p]++;
      end
    end
    if (wr_valid && wr_ack) begin
      apply_word_write(wr);
    end
    if (fill.vld) begin
      apply_refill(fill);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      report_failure($sformatf("timeout, run did not finish within %0d cycles", MaxCycles));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rd_ack))
    else report_failure($sformatf("[ERROR] %0t rd_ack_o got %b expected at most one bit",
                                  $time, $sampled(rd_ack)));

  a_fill_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fill.vld |-> (rd_ack == '0) && !wr_ack)
    else report_failure($sformatf("[ERROR] %0t rd_ack_o,wr_ack_o got %b,%b expected 0,0",
                                  $time, $sampled(rd_ack), $sampled(wr_ack)));

  a_prio: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (|(rd_valid & prio_vec)) && !fill.vld |->
      ((rd_ack & ~(rd_valid & prio_vec)) == '0) && (rd_ack != '0))
    else report_failure($sformatf("[ERROR] %0t rd_ack_o got %b expected one of %b",
                                  $time, $sampled(rd_ack), $sampled(rd_valid & prio_vec)));

  a_wr_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wr_valid |-> wr_ack == exp_wr_ack)
    else report_failure($sformatf("[ERROR] %0t wr_ack_o got %b expected %b",
                                  $time, $sampled(wr_ack), $sampled(exp_wr_ack)));

  a_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_check |-> rd_rsp == exp_rsp_chk)
    else report_failure($sformatf("[ERROR] %0t rd_rsp_o got %h expected %h",
                                  $time, $sampled(rd_rsp), $sampled(exp_rsp_chk)));

  a_idle_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !rsp_check |-> rd_rsp.hit_oh == '0)
    else report_failure($sformatf("[ERROR] %0t rd_rsp_o.hit_oh got %b expected 0",
                                  $time, $sampled(rd_rsp.hit_oh)));

  a_round_robin: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rr_phase |-> (ack_gap[0] < 3) && (ack_gap[1] < 3) && (ack_gap[2] < 3))
    else report_failure($sformatf("[ERROR] %0t rd_ack_o gaps got %0d %0d %0d expected below 3",
                                  $time, ack_gap[0], ack_gap[1], ack_gap[2]));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    dcache_pkg::rd_req_t   r;
    dcache_pkg::fill_req_t f;
    dcache_pkg::word_wr_t  w;
    logic [31:0]           v;
    rng_state    = 32'h67a8_af3c;
    rst_ni       = 1'b0;
    rd_req       = '0;
    rd_valid     = '0;
    fill         = '0;
    wr           = '0;
    wr_valid     = 1'b0;
    ack_pend     = 1'b0;
    rsp_check    = 1'b0;
    exp_wr_ack   = 1'b1;
    rr_phase     = 1'b0;
    exp_rsp_pend = '0;
    exp_rsp_chk  = '0;
    cycles       = 0;
    for (int p = 0; p < NumPorts; p++) begin
      ack_gap[p] = 0;
    end
    for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
      for (int y = 0; y < dcache_pkg::NUM_WAYS; y++) begin
        m_tag[y][s] = '0;
        m_vld[y][s] = 1'b0;
        for (int k = 0; k < dcache_pkg::NUM_BANKS; k++) begin
          m_data[k][s][y] = '0;
        end
      end
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // every set is empty after reset
    for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
      r     = rand_req();
      r.idx = s[dcache_pkg::IDX_WIDTH-1:0];
      issue_read(s % NumPorts, r);
    end

    // refills each followed by a hit, a tag-only read and a miss of the same set
    for (int n = 0; n < 24; n++) begin
      f = rand_fill();
      issue_fill(f);
      r          = rand_req();
      r.idx      = f.idx;
      r.tag      = f.tag;
      r.tag_only = 1'b0;
      issue_read(n % NumPorts, r);
      r.tag_only = 1'b1;
      issue_read((n + 1) % NumPorts, r);
      r.tag      = r.tag ^ 8'h80;
      r.tag_only = 1'b0;
      issue_read((n + 2) % NumPorts, r);
    end

    // refill blocks everything and then port 0 masks the low priority ports
    @(negedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      rd_req[p] = rand_req();
    end
    rd_req[0].prio = 1'b1;
    rd_valid       = '1;
    fill           = rand_fill();
    repeat (2) @(negedge clk_i);
    fill.vld = 1'b0;
    repeat (6) @(negedge clk_i);
    rd_valid[0] = 1'b0;
    repeat (6) @(negedge clk_i);
    rd_valid = '0;

    // equal priority round robin
    @(negedge clk_i);
    rd_req[0].prio = 1'b0;
    rd_valid       = '1;
    rr_phase       = 1'b1;
    repeat (30) @(negedge clk_i);
    rd_valid = '0;
    rr_phase = 1'b0;

    // word writes against reads of set 40 where way 1 holds tag 8'h5d
    f          = rand_fill();
    f.ways     = 4'b0010;
    f.tag      = 8'h5d;
    f.idx      = 6'd40;
    f.vld_bits = '1;
    issue_fill(f);
    for (int n = 0; n < 12; n++) begin
      v          = lcg_next();
      w.ways     = v[3:0];
      w.idx      = 6'd40;
      w.bank_sel = v[5:4];
      w.be       = v[9:6];
      w.data     = lcg_next();
      r          = rand_req();
      r.idx      = 6'd40;
      r.tag      = 8'h5d;
      r.bank_sel = w.bank_sel;
      if (n % 3 == 2) begin
        // the next bank over, never the bank of the write
        r.bank_sel = w.bank_sel + 1'b1;
      end
      r.tag_only = (n % 3 == 1);
      fork
        issue_read(0, r);
        issue_write(w);
      join
      r.bank_sel = w.bank_sel;
      r.tag_only = 1'b0;
      issue_read(1, r);
    end

    repeat (3) @(negedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
source/dcache_pkg.sv
source/dcache_sram.sv
source/dcache_port_arbiter.sv
source/dcache_bank_ctrl.sv
source/dcache_hit_select.sv
source/dcache_mem.sv
bench/dcache_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache memory testbench, pass only when the pass line is printed
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module dcache_mem_tb -f verilog.f \
    -o sim_dcache_mem &&
  ./obj_dir/sim_dcache_mem | tee /dev/stderr | grep -qF '*** PASSED ***' &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
